// File: all.f
+incdir+.
vec_types_pkg.sv
vec_ctrl_pkg.sv
tile_sequencer.sv
tile_adder.sv
vector_add.sv
tb_clk_gen.sv
tb_vector_add.sv

// File: tb_vector_add.sv
`timescale 1ns/1ps

`include "vec_defines.svh"

module tb_vector_add;

    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 200;
    // Fixed pair, extreme, random, busy pair, back-to-back pair
    localparam int NUM_VECTORS  = 2 + 1 + NUM_RANDOM + 2 + 2;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * (NUM_TILES + 4) + RESET_CYCLES + 50;
    localparam int RES_BITS     = $bits(result_vec_t);

    logic        clk;
    logic        rst_n;
    logic        start;
    vec_op_e     op;
    a_vec_t      a;
    b_vec_t      b;
    result_vec_t result;
    logic        valid;
    logic        busy;

    // Expected results and their test names, in acceptance order
    result_vec_t exp_q [$];
    string       name_q [$];
    string       test_name = "none";

    // Cycles left until valid, 0 when the model is idle
    int          countdown = 0;
    int          cyc = 0;
    logic        out_of_reset = 1'b0;
    int          mismatches = 0;
    int          other_errors = 0;
    logic [31:0] lfsr_state = 32'h4b98_eda9;

    tb_clk_gen clk_gen_inst (.clk(clk));

    vector_add vector_add_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .valid  (valid),
        .busy   (busy)
    );

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // Random cell, about one in eight pinned to an edge value
    function automatic int rand_cell(input int width);
        int lo;
        int hi;
        lo = -(1 << (width - 1));
        hi = (1 << (width - 1)) - 1;
        if (next_bits(3) == 0) begin
            case (next_bits(2))
                0: return lo;
                1: return hi;
                2: return 0;
                default: return -1;
            endcase
        end
        return int'(next_bits(width));
    endfunction

    // Expected vector: widen both cells with sign, then add or subtract
    function automatic result_vec_t ref_vector_op(input a_vec_t va, input b_vec_t vb,
                                                  input vec_op_e vop);
        result_vec_t  r;
        result_cell_t ea;
        result_cell_t eb;
        for (int i = 0; i < `VECTOR_LEN; i++) begin
            ea = va[i];
            eb = vb[i];
            r[i] = (vop == op_add) ? ea + eb : ea - eb;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [RES_BITS-1:0] expected,
                               input logic [RES_BITS-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Called just after a rising edge, returns just after the edge that samples start
    task automatic drive_start(input a_vec_t va, input b_vec_t vb, input vec_op_e vop);
        start <= 1'b1;
        a     <= va;
        b     <= vb;
        op    <= vop;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_valid();
        do begin
            @(posedge clk);
        end while (valid !== 1'b1);
    endtask

    ////////////////////
    // Monitor
    ////////////////////

    // Samples pre-edge values, so DUT flop updates never race the compare
    always @(posedge clk) begin : monitor
        logic        exp_valid;
        logic        exp_busy;
        result_vec_t exp_r;
        string       exp_name;
        cyc++;
        if (!rst_n) begin
            // Sync reset, outputs known from the second edge on
            if (cyc > 1 && (valid !== 1'b0 || busy !== 1'b0)) begin
                other_errors++;
                $display("valid or busy high during reset at cycle %0d", cyc);
            end
        end else begin
            if (!out_of_reset) begin
                check_value("reset_result", '0, result);
                out_of_reset = 1'b1;
            end
            exp_valid = (countdown == 1);
            exp_busy  = (countdown > 1);
            check_value("busy", exp_busy, busy);
            if (exp_valid) begin
                exp_r    = exp_q.pop_front();
                exp_name = name_q.pop_front();
                if (valid !== 1'b1) begin
                    other_errors++;
                    $display("Missing valid for %s at cycle %0d", exp_name, cyc);
                end else begin
                    check_value(exp_name, exp_r, result);
                end
            end else if (valid !== 1'b0) begin
                other_errors++;
                $display("Extra valid pulse at cycle %0d", cyc);
            end
            if (countdown > 0) begin
                countdown--;
            end
            // Start taken only when the model is idle, valid cycle included
            if (start === 1'b1 && countdown == 0) begin
                exp_q.push_back(ref_vector_op(a, b, op));
                name_q.push_back(test_name);
                countdown = NUM_TILES + 1;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        a_vec_t  va;
        b_vec_t  vb;
        vec_op_e vop;
        int      fix_a [5];
        int      fix_b [5];
        fix_a = '{-10, 20, 30, 40, -50};
        fix_b = '{5, 4, -3, 2, 1};
        rst_n = 1'b0;
        start = 1'b0;
        op    = op_add;
        a     = '0;
        b     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);

        // Fixture operands, cell 0 first
        for (int i = 0; i < `VECTOR_LEN; i++) begin
            va[i] = a_cell_t'(fix_a[i % 5]);
            vb[i] = b_cell_t'(fix_b[i % 5]);
        end
        test_name = "fixed_add";
        drive_start(va, vb, op_add);
        wait_valid();
        test_name = "fixed_sub";
        drive_start(va, vb, op_sub);
        wait_valid();

        // Most negative minus most positive in every cell
        for (int i = 0; i < `VECTOR_LEN; i++) begin
            va[i] = a_cell_t'(-(1 << (`A_CELL_WIDTH - 1)));
            vb[i] = b_cell_t'((1 << (`B_CELL_WIDTH - 1)) - 1);
        end
        test_name = "extreme_sub";
        drive_start(va, vb, op_sub);
        wait_valid();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            for (int i = 0; i < `VECTOR_LEN; i++) begin
                va[i] = a_cell_t'(rand_cell(`A_CELL_WIDTH));
                vb[i] = b_cell_t'(rand_cell(`B_CELL_WIDTH));
            end
            vop = vec_op_e'(next_bits(1));
            test_name = $sformatf("random_%0d", n);
            drive_start(va, vb, vop);
            wait_valid();
        end

        // Second start lands while busy, with different operands
        test_name = "start_while_busy";
        drive_start(va, vb, op_add);
        drive_start(~va, ~vb, op_sub);
        wait_valid();

        // Second start held up in exactly the valid cycle
        test_name = "start_on_valid_first";
        drive_start(va, vb, op_sub);
        repeat (NUM_TILES) @(posedge clk);
        test_name = "start_on_valid_second";
        drive_start(~va, vb, op_add);
        wait_valid();

        repeat (NUM_TILES + 3) @(posedge clk);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Missing valid: %0d accepted vectors never completed", exp_q.size());
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    ////////////////////
    // Clock source
    ////////////////////

    // Free running, starts low so the first edge is a rising one
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

// File: vector_add.sv
`timescale 1ns/1ps

module vector_add (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  vec_ctrl_pkg::vec_op_e      op,
    input  vec_types_pkg::a_vec_t      a,
    input  vec_types_pkg::b_vec_t      b,
    output vec_types_pkg::result_vec_t result,
    output logic                       valid,
    output logic                       busy
);

    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    ////////////////////
    // Internal wires
    ////////////////////

    // Start taken while idle
    logic      accept;

    // Tile write strobe and its index
    logic      tile_en;
    tile_idx_t tile_idx;

    ////////////////////
    // Control
    ////////////////////

    // Steps the tiles, owns valid and busy
    tile_sequencer tile_sequencer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .accept   (accept),
        .tile_en  (tile_en),
        .tile_idx (tile_idx),
        .valid    (valid),
        .busy     (busy)
    );

    ////////////////////
    // Datapath
    ////////////////////

    // Operand latch, lanes and result register
    tile_adder tile_adder_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .accept   (accept),
        .tile_en  (tile_en),
        .tile_idx (tile_idx),
        .op       (op),
        .a        (a),
        .b        (b),
        .result   (result)
    );

    ////////////////////
    // Handshake checks
    ////////////////////

    // Valid only comes from idle, so a start in that cycle is taken
    a_valid_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid |-> !busy
    ) else $error("valid raised while busy");

    // Busy for every tile cycle, then valid with busy low
    a_busy_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |=> busy [*NUM_TILES] ##1 (valid && !busy)
    ) else $error("busy or valid timing off after accepted start");

endmodule

// File: tile_adder.sv
`timescale 1ns/1ps

`include "vec_defines.svh"

module tile_adder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       accept,
    input  logic                       tile_en,
    input  vec_ctrl_pkg::tile_idx_t    tile_idx,
    input  vec_ctrl_pkg::vec_op_e      op,
    input  vec_types_pkg::a_vec_t      a,
    input  vec_types_pkg::b_vec_t      b,
    output vec_types_pkg::result_vec_t result
);

    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;

    // Latched operands and op
    a_vec_t  a_q;
    b_vec_t  b_q;
    vec_op_e op_q;

    // Per-lane cell index, raw and clamped
    int           lane_cell [`TILING];
    int           lane_sel  [`TILING];
    logic         lane_ok   [`TILING];

    // Per-lane extended operands and result
    result_cell_t lane_ext_a [`TILING];
    result_cell_t lane_ext_b [`TILING];
    result_cell_t lane_res   [`TILING];

    // Result must have headroom over both operands
    if (`RESULT_CELL_WIDTH <= `A_CELL_WIDTH || `RESULT_CELL_WIDTH <= `B_CELL_WIDTH) begin : g_chk
        $error("RESULT_CELL_WIDTH too narrow for operand cells");
    end

    ////////////////////
    // Operand capture
    ////////////////////

    // Sampled on the accept edge, inputs free afterwards
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q  <= a;
            b_q  <= b;
            op_q <= op;
        end
    end

    ////////////////////
    // Lanes
    ////////////////////

    for (genvar lane = 0; lane < `TILING; lane++) begin : g_lane
        // Cell at tile base plus lane number
        assign lane_cell[lane] = int'(tile_idx) * `TILING + lane;

        // Lanes past the vector end in a partial tile
        assign lane_ok[lane]  = (lane_cell[lane] < `VECTOR_LEN);
        assign lane_sel[lane] = lane_ok[lane] ? lane_cell[lane] : 0;

        // Signed size cast does the sign extension
        assign lane_ext_a[lane] = result_cell_t'(a_q[lane_sel[lane]]);
        assign lane_ext_b[lane] = result_cell_t'(b_q[lane_sel[lane]]);

        assign lane_res[lane] = (op_q == op_sub) ? lane_ext_a[lane] - lane_ext_b[lane]
                                                 : lane_ext_a[lane] + lane_ext_b[lane];
    end

    ////////////////////
    // Result register
    ////////////////////

    // One tile per tile_en edge, rest of the vector held
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (tile_en) begin
            for (int lane = 0; lane < `TILING; lane++) begin
                if (lane_ok[lane]) begin
                    result[lane_sel[lane]] <= lane_res[lane];
                end
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Operands never reload while a tile is being written
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(tile_en && accept)
    ) else $error("accept seen during tile write");

endmodule

// File: tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    output logic                    accept,
    output logic                    tile_en,
    output vec_ctrl_pkg::tile_idx_t tile_idx,
    output logic                    valid,
    output logic                    busy
);

    import vec_ctrl_pkg::*;

    seq_state_e state;
    logic       last_tile;

    ////////////////////
    // Decode
    ////////////////////

    // Start only counts while idle
    assign accept = start && (state == st_idle);

    // One tile per running cycle
    assign tile_en = (state == st_run);
    assign busy    = (state == st_run);

    // Final tile of the vector
    assign last_tile = (tile_idx == tile_idx_t'(NUM_TILES - 1));

    ////////////////////
    // State and counter
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            tile_idx <= '0;
            valid    <= 1'b0;
        end else begin
            // Valid is a strobe, cleared by default
            valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state    <= st_run;
                        tile_idx <= '0;
                    end
                end
                st_run: begin
                    if (last_tile) begin
                        // Last tile lands on this edge
                        state    <= st_idle;
                        tile_idx <= '0;
                        valid    <= 1'b1;
                    end else begin
                        tile_idx <= tile_idx_t'(tile_idx + 1'b1);
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Counter never walks past the last tile
    a_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        tile_idx < tile_idx_t'(NUM_TILES)
    ) else $error("tile_idx out of range: %0d", tile_idx);

    // Valid is a single-cycle strobe
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid |=> !valid
    ) else $error("valid held longer than one cycle");

endmodule

// File: vec_ctrl_pkg.sv
`include "vec_defines.svh"

package vec_ctrl_pkg;

    // Operation code, add for weight update, sub for output error
    typedef enum logic {op_add = 1'b0, op_sub = 1'b1} vec_op_e;

    // Sequencer state
    typedef enum logic {st_idle = 1'b0, st_run = 1'b1} seq_state_e;

    // Tiles per vector, last one may be partial
    localparam int NUM_TILES = (`VECTOR_LEN + `TILING - 1) / `TILING;

    // Index width, holds NUM_TILES itself
    localparam int TILE_IDX_W = $clog2(NUM_TILES + 1);

    typedef logic [TILE_IDX_W-1:0] tile_idx_t;

endpackage

// File: vec_types_pkg.sv
`include "vec_defines.svh"

package vec_types_pkg;

    ////////////////////
    // Cell types
    ////////////////////

    // Operand cells, one signed word each
    typedef logic signed [`A_CELL_WIDTH-1:0] a_cell_t;
    typedef logic signed [`B_CELL_WIDTH-1:0] b_cell_t;

    // Result cell, wide enough that add or subtract never wraps
    typedef logic signed [`RESULT_CELL_WIDTH-1:0] result_cell_t;

    ////////////////////
    // Whole vectors
    ////////////////////

    // Cell 0 in the lowest bits
    typedef a_cell_t      [`VECTOR_LEN-1:0] a_vec_t;
    typedef b_cell_t      [`VECTOR_LEN-1:0] b_vec_t;
    typedef result_cell_t [`VECTOR_LEN-1:0] result_vec_t;

endpackage

// File: vec_defines.svh
`ifndef VEC_DEFINES_SVH
`define VEC_DEFINES_SVH

////////////////////
// Vector geometry
////////////////////

// Cells per vector
`define VECTOR_LEN 5

// Signed operand widths
`define A_CELL_WIDTH 8
`define B_CELL_WIDTH 8

// Signed result width, at least one bit over the wider operand
`define RESULT_CELL_WIDTH 24

// Cells handled per clock, 1 up to VECTOR_LEN
`define TILING 2

`endif
